//--- verilog/dport_pkg.sv
`default_nettype none

package dport_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  // Byte address width on both the core and the bus side
  localparam int unsigned ADDR_W = 32;

  // Read and write data width
  localparam int unsigned DATA_W = 32;

  // One byte enable per data byte
  localparam int unsigned BE_W = DATA_W / 8;

  ////////////////////////////////////////////////////////////
  // Write buffer
  ////////////////////////////////////////////////////////////

  // A single entry needs only one state bit
  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

  // Bufferable region is the upper half of the 64 KiB window at address zero
  // An address hits the region when (addr & MASK) == BASE
  localparam logic [ADDR_W-1:0] BUF_REGION_BASE = 32'h0000_8000;
  localparam logic [ADDR_W-1:0] BUF_REGION_MASK = 32'hFFFF_8000;

  ////////////////////////////////////////////////////////////
  // Outstanding transactions
  ////////////////////////////////////////////////////////////

  // Granted bus transactions still waiting for their response
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Wide enough to hold 0 up to MAX_OUTSTANDING inclusive
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

endpackage

`default_nettype wire

//--- verilog/write_buffer.sv
`default_nettype none

module write_buffer (
  input  logic                         clk,
  input  logic                         rst_n,

  // Upstream request from the load/store unit
  input  logic                         req_i,
  input  logic [dport_pkg::ADDR_W-1:0] addr_i,
  input  logic                         we_i,
  input  logic [dport_pkg::BE_W-1:0]   be_i,
  input  logic [dport_pkg::DATA_W-1:0] wdata_i,
  output logic                         gnt_o,

  // Downstream request towards the outstanding controller
  output logic                         req_o,
  output logic [dport_pkg::ADDR_W-1:0] addr_o,
  output logic                         we_o,
  output logic [dport_pkg::BE_W-1:0]   be_o,
  output logic [dport_pkg::DATA_W-1:0] wdata_o,
  input  logic                         gnt_i
);

  dport_pkg::wbuf_state_e state_q;
  dport_pkg::wbuf_state_e state_d;

  // Set when the incoming write is taken into the entry on this edge
  logic capture;
  logic bufferable;

  // Held entry, always a write so no write enable is stored
  logic [dport_pkg::ADDR_W-1:0] addr_q;
  logic [dport_pkg::BE_W-1:0]   be_q;
  logic [dport_pkg::DATA_W-1:0] wdata_q;

  ////////////////////////////////////////////////////////////
  // Region decode
  ////////////////////////////////////////////////////////////

  // Only a valid write into the bufferable region may be absorbed
  assign bufferable = req_i && we_i &&
                      ((addr_i & dport_pkg::BUF_REGION_MASK) == dport_pkg::BUF_REGION_BASE);

  ////////////////////////////////////////////////////////////
  // State and capture control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    capture = 1'b0;
    case (state_q)
      dport_pkg::WBUF_EMPTY: begin
        // A stalled bufferable write is taken over by the buffer
        if (bufferable && !gnt_i) begin
          capture = 1'b1;
          state_d = dport_pkg::WBUF_FULL;
        end
      end
      dport_pkg::WBUF_FULL: begin
        // The held entry drains on gnt_i
        // A bufferable write waiting behind it refills the entry on the same edge
        if (gnt_i) begin
          if (bufferable) begin
            capture = 1'b1;
          end else begin
            state_d = dport_pkg::WBUF_EMPTY;
          end
        end
      end
      default: begin
        state_d = dport_pkg::WBUF_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dport_pkg::WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q  <= addr_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (state_q == dport_pkg::WBUF_FULL) begin
      // The held write goes first, so nothing can overtake it
      req_o   = 1'b1;
      addr_o  = addr_q;
      we_o    = 1'b1;
      be_o    = be_q;
      wdata_o = wdata_q;
      // Only a bufferable write may enter, and only as the entry drains
      gnt_o   = bufferable && gnt_i;
    end else begin
      // Empty buffer is transparent
      req_o   = req_i;
      addr_o  = addr_i;
      we_o    = we_i;
      be_o    = be_i;
      wdata_o = wdata_i;
      // A bufferable write is accepted whether or not downstream is ready
      gnt_o   = req_i && (bufferable || gnt_i);
    end
  end

endmodule

`default_nettype wire

//--- verilog/obi_outstanding_ctrl.sv
`default_nettype none

module obi_outstanding_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,

  // Request from the write buffer
  input  logic                         req_i,
  input  logic [dport_pkg::ADDR_W-1:0] addr_i,
  input  logic                         we_i,
  input  logic [dport_pkg::BE_W-1:0]   be_i,
  input  logic [dport_pkg::DATA_W-1:0] wdata_i,
  output logic                         gnt_o,

  // Bus address phase
  output logic                         bus_req_o,
  output logic [dport_pkg::ADDR_W-1:0] bus_addr_o,
  output logic                         bus_we_o,
  output logic [dport_pkg::BE_W-1:0]   bus_be_o,
  output logic [dport_pkg::DATA_W-1:0] bus_wdata_o,
  input  logic                         bus_gnt_i,

  // Bus response phase
  input  logic                         bus_rvalid_i,
  input  logic [dport_pkg::DATA_W-1:0] bus_rdata_i,
  input  logic                         bus_err_i,

  // Response towards the core
  output logic                         rvalid_o,
  output logic [dport_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o
);

  logic [dport_pkg::CNT_W-1:0] cnt_q;
  logic [dport_pkg::CNT_W-1:0] cnt_d;

  // A new request may issue while there is room in the counter
  logic room;
  logic accept;

  ////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////

  // A response in this cycle frees a slot before the edge
  assign room = (cnt_q < dport_pkg::CNT_W'(dport_pkg::MAX_OUTSTANDING)) || bus_rvalid_i;

  // The request stays off the bus while the limit is reached
  // Once raised it stays up, since the count cannot grow without a grant
  assign bus_req_o   = req_i && room;
  assign bus_addr_o  = addr_i;
  assign bus_we_o    = we_i;
  assign bus_be_o    = be_i;
  assign bus_wdata_o = wdata_i;

  assign accept = bus_req_o && bus_gnt_i;
  assign gnt_o  = accept;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    case ({accept, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      // A grant and a response together leave the count unchanged
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////

  // Responses come back in order, so they go to the core untouched
  assign rvalid_o = bus_rvalid_i;
  assign rdata_o  = bus_rdata_i;
  assign err_o    = bus_err_i;

endmodule

`default_nettype wire

//--- verilog/data_port.sv
`default_nettype none

module data_port (
  input  logic                         clk,
  input  logic                         rst_n,

  // Core request
  input  logic                         core_req_i,
  input  logic [dport_pkg::ADDR_W-1:0] core_addr_i,
  input  logic                         core_we_i,
  input  logic [dport_pkg::BE_W-1:0]   core_be_i,
  input  logic [dport_pkg::DATA_W-1:0] core_wdata_i,
  output logic                         core_gnt_o,

  // Core response
  output logic                         core_rvalid_o,
  output logic [dport_pkg::DATA_W-1:0] core_rdata_o,
  output logic                         core_err_o,

  // Bus request
  output logic                         bus_req_o,
  output logic [dport_pkg::ADDR_W-1:0] bus_addr_o,
  output logic                         bus_we_o,
  output logic [dport_pkg::BE_W-1:0]   bus_be_o,
  output logic [dport_pkg::DATA_W-1:0] bus_wdata_o,
  input  logic                         bus_gnt_i,

  // Bus response
  input  logic                         bus_rvalid_i,
  input  logic [dport_pkg::DATA_W-1:0] bus_rdata_i,
  input  logic                         bus_err_i
);

  // Request between the write buffer and the outstanding controller
  logic                         wb_req;
  logic [dport_pkg::ADDR_W-1:0] wb_addr;
  logic                         wb_we;
  logic [dport_pkg::BE_W-1:0]   wb_be;
  logic [dport_pkg::DATA_W-1:0] wb_wdata;
  logic                         wb_gnt;

  ////////////////////////////////////////////////////////////
  // Write buffer on the core side
  ////////////////////////////////////////////////////////////

  write_buffer u_wbuf (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (core_req_i),
    .addr_i  (core_addr_i),
    .we_i    (core_we_i),
    .be_i    (core_be_i),
    .wdata_i (core_wdata_i),
    .gnt_o   (core_gnt_o),
    .req_o   (wb_req),
    .addr_o  (wb_addr),
    .we_o    (wb_we),
    .be_o    (wb_be),
    .wdata_o (wb_wdata),
    .gnt_i   (wb_gnt)
  );

  ////////////////////////////////////////////////////////////
  // Outstanding limit on the bus side
  ////////////////////////////////////////////////////////////

  obi_outstanding_ctrl u_octrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (wb_req),
    .addr_i       (wb_addr),
    .we_i         (wb_we),
    .be_i         (wb_be),
    .wdata_i      (wb_wdata),
    .gnt_o        (wb_gnt),
    .bus_req_o    (bus_req_o),
    .bus_addr_o   (bus_addr_o),
    .bus_we_o     (bus_we_o),
    .bus_be_o     (bus_be_o),
    .bus_wdata_o  (bus_wdata_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_err_i    (bus_err_i),
    .rvalid_o     (core_rvalid_o),
    .rdata_o      (core_rdata_o),
    .err_o        (core_err_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_obi_mem.sv
`default_nettype none

module tb_obi_mem (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         req_i,
  input  logic [dport_pkg::ADDR_W-1:0] addr_i,
  input  logic                         we_i,
  input  logic [dport_pkg::BE_W-1:0]   be_i,
  input  logic [dport_pkg::DATA_W-1:0] wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [dport_pkg::DATA_W-1:0] rdata_o,
  output logic                         err_o
);

  // One word per 4 bytes of the 64 KiB window
  localparam int WORDS = 16384;

  logic [dport_pkg::DATA_W-1:0] mem [0:WORDS-1];

  // Pending responses in bus order, each with the cycle it is sent on
  logic [dport_pkg::DATA_W-1:0] resp_data_q[$];
  int                           resp_due_q[$];

  integer seed;
  int     stall;
  int     cyc;
  int     last_due;
  int     due;
  int     idx;
  logic [dport_pkg::DATA_W-1:0] rd;

  // Upper half of each word holds its byte address, lower half the inverse
  initial begin
    seed = 23351;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = {i[13:0], 2'b00, ~{i[13:0], 2'b00}};
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      stall    = 0;
      cyc      = 0;
      last_due = 0;
    end else begin
      cyc = cyc + 1;
      ////////////////////////////////////////////////////////////
      // Address phase
      ////////////////////////////////////////////////////////////
      if (req_i && gnt_o) begin
        idx = int'(addr_i[15:2]);
        // Read data is taken before any lane of this word changes
        rd = we_i ? '0 : mem[idx];
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
              mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
        end
        // Between one and four cycles later, never two on one cycle
        due = cyc + int'($random(seed) & 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        resp_data_q.push_back(rd);
        resp_due_q.push_back(due);
        stall = int'($random(seed) & 3);
      end else if (req_i && stall > 0) begin
        stall = stall - 1;
      end
      gnt_o <= (stall == 0);
      ////////////////////////////////////////////////////////////
      // Response phase
      ////////////////////////////////////////////////////////////
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cyc) begin
        rvalid_o <= 1'b1;
        rdata_o  <= resp_data_q.pop_front();
        void'(resp_due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_data_port.sv
`default_nettype none

module tb_data_port;

  localparam int NUM_REQUESTS = 300;
  localparam int WAIT_LIMIT   = 200;

  logic clk;
  logic rst_n;
  logic core_req, core_we, core_gnt, core_rvalid, core_err;
  logic [dport_pkg::ADDR_W-1:0] core_addr;
  logic [dport_pkg::BE_W-1:0]   core_be;
  logic [dport_pkg::DATA_W-1:0] core_wdata, core_rdata;
  logic bus_req, bus_we, bus_gnt, bus_rvalid, bus_err;
  logic [dport_pkg::ADDR_W-1:0] bus_addr;
  logic [dport_pkg::BE_W-1:0]   bus_be;
  logic [dport_pkg::DATA_W-1:0] bus_wdata, bus_rdata;
  logic core_bufferable;

  // Reference memory covers 8 words below and 8 words inside the region
  logic [dport_pkg::DATA_W-1:0] ref_mem [0:15];
  logic [dport_pkg::DATA_W-1:0] exp_q[$];
  // Core grants not yet seen on the bus, as {addr, we, be, wdata}
  logic [68:0] order_q[$];
  logic [68:0] seen;
  logic [dport_pkg::DATA_W-1:0] expected;
  int   idx;
  int   pending;
  int   outstanding;
  integer seed = 23351;

  data_port dut0 (
    .clk (clk), .rst_n (rst_n),
    .core_req_i (core_req), .core_addr_i (core_addr), .core_we_i (core_we),
    .core_be_i (core_be), .core_wdata_i (core_wdata), .core_gnt_o (core_gnt),
    .core_rvalid_o (core_rvalid), .core_rdata_o (core_rdata), .core_err_o (core_err),
    .bus_req_o (bus_req), .bus_addr_o (bus_addr), .bus_we_o (bus_we), .bus_be_o (bus_be),
    .bus_wdata_o (bus_wdata), .bus_gnt_i (bus_gnt),
    .bus_rvalid_i (bus_rvalid), .bus_rdata_i (bus_rdata), .bus_err_i (bus_err)
  );

  tb_obi_mem u_mem (
    .clk (clk), .rst_n (rst_n), .req_i (bus_req), .addr_i (bus_addr), .we_i (bus_we),
    .be_i (bus_be), .wdata_i (bus_wdata), .gnt_o (bus_gnt),
    .rvalid_o (bus_rvalid), .rdata_o (bus_rdata), .err_o (bus_err)
  );

  always #2 clk = ~clk;

  // A write into the upper half of the window may be absorbed by the buffer
  assign core_bufferable = core_req && core_we &&
    ((core_addr & dport_pkg::BUF_REGION_MASK) == dport_pkg::BUF_REGION_BASE);

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) word[8*b +: 8] = wdata[8*b +: 8];
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////

  core_hold: assert property (@(posedge clk) disable iff (!rst_n)
    core_req && !core_gnt |=> core_req && $stable(core_addr) && $stable(core_we)
      && $stable(core_be) && $stable(core_wdata))
    else abort_run($sformatf("** Error at time %0t: core request changed before grant", $time));

  bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req && !bus_gnt |=> bus_req && $stable(bus_addr) && $stable(bus_we)
      && $stable(bus_be) && $stable(bus_wdata))
    else abort_run($sformatf("** Error at time %0t: bus request changed before grant", $time));

  // Empty buffer and idle bus path, so a stalled bufferable write is still taken
  buffer_accept: assert property (@(posedge clk) disable iff (!rst_n)
    core_bufferable && !bus_gnt && pending == 0 |-> core_gnt)
    else abort_run($sformatf("** Error at time %0t: bufferable write not granted", $time));

  // Anything else only goes through once all earlier grants reached the bus
  strict_order: assert property (@(posedge clk) disable iff (!rst_n)
    core_req && core_gnt && !core_bufferable |-> pending == 0 && bus_req && bus_gnt)
    else abort_run($sformatf("** Error at time %0t: request overtook a buffered write", $time));

  limit_kept: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= int'(dport_pkg::MAX_OUTSTANDING))
    else abort_run($sformatf("** Error at time %0t: %0d bus transactions outstanding",
                             $time, outstanding));

  reset_quiet: assert property (@(posedge clk)
    (!rst_n || !$past(rst_n)) && !core_req |-> !core_gnt && !core_rvalid && !bus_req)
    else abort_run($sformatf("** Error at time %0t: port active around reset", $time));

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending     <= 0;
      outstanding <= 0;
    end else begin
      pending     <= pending + int'(core_req && core_gnt) - int'(bus_req && bus_gnt);
      outstanding <= outstanding + int'(bus_req && bus_gnt) - int'(bus_rvalid);
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // Grants are logged before the bus pops them, since both can share one edge
      if (core_req && core_gnt) begin
        order_q.push_back({core_addr, core_we, core_be, core_wdata});
        idx = int'({core_addr[15], core_addr[4:2]});
        if (core_we) begin
          ref_mem[idx] = merge_bytes(ref_mem[idx], core_wdata, core_be);
          exp_q.push_back('0);
        end else begin
          exp_q.push_back(ref_mem[idx]);
        end
      end
      if (bus_req && bus_gnt) begin
        assert (order_q.size() > 0)
          else abort_run("A bus request was granted with no core grant behind it");
        seen = order_q.pop_front();
        assert (seen == {bus_addr, bus_we, bus_be, bus_wdata})
          else abort_run($sformatf("** Error at time %0t: bus request %h %b %h %h, expected %h",
                                   $time, bus_addr, bus_we, bus_be, bus_wdata, seen));
      end
      if (core_rvalid) begin
        assert (exp_q.size() > 0)
          else abort_run("A core response arrived with no granted request waiting for it");
        expected = exp_q.pop_front();
        assert (core_rdata == expected && !core_err)
          else abort_run($sformatf("** Error at time %0t: response %h err %b, expected %h",
                                   $time, core_rdata, core_err, expected));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_request(input logic [31:0] addr, input logic we,
                              input logic [3:0] be, input logic [31:0] wdata);
    int   waited;
    logic granted;
    waited     = 0;
    granted    = 1'b0;
    core_req   = 1'b1;
    core_addr  = addr;
    core_we    = we;
    core_be    = be;
    core_wdata = wdata;
    while (!granted) begin
      @(posedge clk);
      granted = core_gnt;
      waited++;
      if (!granted && waited >= WAIT_LIMIT) begin
        abort_run("Timeout while waiting for a core grant");
      end
    end
    #1;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [3:0]  be;
    int          waited;
    clk        = 1'b0;
    rst_n      = 1'b0;
    core_req   = 1'b0;
    core_addr  = '0;
    core_we    = 1'b0;
    core_be    = '0;
    core_wdata = '0;
    // Same fill as the bus memory, word address in the upper half
    for (int k = 0; k < 16; k++) begin
      ref_mem[k] = {k[3], 10'd0, k[2:0], 2'b00, ~{k[3], 10'd0, k[2:0], 2'b00}};
    end
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_REQUESTS; n++) begin
      rnd = $random(seed);
      // An idle cycle now and then lets the buffer drain
      if (rnd[7:5] == 3'd0) begin
        core_req = 1'b0;
        @(posedge clk);
        #1;
      end
      addr = {16'h0000, rnd[0], 10'd0, rnd[4:2], 2'b00};
      be   = (rnd[1] && rnd[11:8] != 4'h0) ? rnd[11:8] : 4'hF;
      send_request(addr, rnd[1], be, $random(seed));
    end
    core_req = 1'b0;
    waited   = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() == 0 && order_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Timeout while waiting for the last core responses");
    end
  end

endmodule

`default_nettype wire

//--- build.f
verilog/dport_pkg.sv
verilog/write_buffer.sv
verilog/obi_outstanding_ctrl.sv
verilog/data_port.sv
sim/tb_obi_mem.sv
sim/tb_data_port.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_data_port
FILELIST   ?= build.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
